// ==== Bender.yml ====
package:
  name: sample_rescaler

sources:
  - hdl/rescale_pkg.sv
  - hdl/regmap_pkg.sv
  - hdl/scale_cfg_if.sv
  - hdl/gain_multiplier.sv
  - hdl/round_saturate.sv
  - hdl/scale_regs.sv
  - hdl/sample_rescaler.sv
  - target: test
    files:
      - tb/sample_rescaler_checker.sv
      - tb/sample_rescaler_tb.sv

// ==== filelist.f ====
hdl/rescale_pkg.sv
hdl/regmap_pkg.sv
hdl/scale_cfg_if.sv
hdl/gain_multiplier.sv
hdl/round_saturate.sv
hdl/scale_regs.sv
hdl/sample_rescaler.sv
tb/sample_rescaler_checker.sv
tb/sample_rescaler_tb.sv

// ==== hdl/gain_multiplier.sv ====
`timescale 1ns/1ps
`default_nettype none

module gain_multiplier (
   input  logic                  CLK,
   input  logic                  RST,
   input  rescale_pkg::sample_t  in_sample,
   input  logic                  in_valid,
   scale_cfg_if.datapath         cfg,
   output rescale_pkg::product_t product,
   output logic                  product_valid
);
   import rescale_pkg::*;

   // Both operands are widened to the product width before the multiply,
   // so the signed result is exact.
   always_ff @(posedge CLK)
   begin
      if (in_valid)
      begin
         product <= product_t'(in_sample) * product_t'(cfg.gain);
      end
   end

   // Samples arriving while the block is disabled are dropped here.
   always_ff @(posedge CLK or posedge RST)
   begin
      if (RST)
      begin
         product_valid <= 1'b0;
      end
      else
      begin
         product_valid <= in_valid && cfg.enable;
      end
   end

endmodule

`default_nettype wire

// ==== hdl/regmap_pkg.sv ====
`default_nettype none

package regmap_pkg;

   localparam int REG_DATA_SZ = 32;

   // Width of the saturating clip counter, zero-extended on read.
   localparam int CLIP_CNT_SZ = 16;

   typedef enum logic [1:0] {
      REG_GAIN       = 2'd0,
      REG_CTRL       = 2'd1, // Bit 0 is the enable.
      REG_CLIP_COUNT = 2'd2  // Any write clears the count.
   } reg_addr_e;

   typedef logic [REG_DATA_SZ-1:0] reg_data_t;

endpackage

`default_nettype wire

// ==== hdl/rescale_pkg.sv ====
`default_nettype none

package rescale_pkg;

   // Datapath widths. The product holds the full result of sample times gain.
   localparam int SAMPLE_SZ  = 16;
   localparam int GAIN_SZ    = 21;
   localparam int PRODUCT_SZ = SAMPLE_SZ + GAIN_SZ;

   localparam int FRAC_SZ = 15; // Fractional bits dropped by rounding.

   // Symmetric clip level, so -32768 is never produced.
   localparam int SAT_MAX = 32767;

   localparam int GAIN_RESET = 32768; // Unity gain in Q5.15.

   // Samples are Q0.15 on both sides of the rescaler.
   typedef logic signed [SAMPLE_SZ-1:0] sample_t;

   typedef logic signed [GAIN_SZ-1:0] gain_t;

   typedef logic signed [PRODUCT_SZ-1:0] product_t;

endpackage

`default_nettype wire

// ==== hdl/round_saturate.sv ====
`timescale 1ns/1ps
`default_nettype none

module round_saturate (
   input  logic                  CLK,
   input  logic                  RST,
   input  rescale_pkg::product_t product,
   input  logic                  product_valid,
   output rescale_pkg::sample_t  out_sample,
   output logic                  out_valid,
   scale_cfg_if.datapath         cfg
);
   import rescale_pkg::*;

   product_t                             sum_d1;
   logic                                 sign_d1;
   logic                                 valid_d1;
   logic signed [PRODUCT_SZ-FRAC_SZ-1:0] rounded;
   logic                                 overflow;
   logic                                 clip_q;

   // Stage one adds half an output LSB, so truncation below rounds to nearest.
   always_ff @(posedge CLK)
   begin
      sum_d1  <= product + (product_t'(1) <<< (FRAC_SZ - 1));
      sign_d1 <= product[PRODUCT_SZ-1];
   end

   always_ff @(posedge CLK or posedge RST)
   begin
      if (RST)
      begin
         valid_d1 <= 1'b0;
      end
      else
      begin
         valid_d1 <= product_valid;
      end
   end

   assign rounded = sum_d1[PRODUCT_SZ-1:FRAC_SZ];

   // The lower bound also catches -32768, which keeps the clip symmetric.
   assign overflow = (rounded > SAT_MAX) || (rounded < -SAT_MAX);

   always_ff @(posedge CLK or posedge RST)
   begin
      if (RST)
      begin
         out_sample <= '0;
         out_valid  <= 1'b0;
         clip_q     <= 1'b0;
      end
      else
      begin
         out_valid <= valid_d1;
         clip_q    <= overflow && valid_d1; // Only real samples are counted.
         if (overflow)
         begin
            out_sample <= sign_d1 ? sample_t'(-SAT_MAX) : sample_t'(SAT_MAX);
         end
         else
         begin
            out_sample <= rounded[SAMPLE_SZ-1:0];
         end
      end
   end

   assign cfg.clip_inc = clip_q;

endmodule

`default_nettype wire

// ==== hdl/sample_rescaler.sv ====
`timescale 1ns/1ps
`default_nettype none

module sample_rescaler (
   input  logic                  CLK,
   input  logic                  RST,
   input  rescale_pkg::sample_t  in_sample,
   input  logic                  in_valid,
   output rescale_pkg::sample_t  out_sample,
   output logic                  out_valid,
   input  logic                  reg_wr,
   input  logic                  reg_rd,
   input  regmap_pkg::reg_addr_e reg_addr,
   input  regmap_pkg::reg_data_t reg_wdata,
   output regmap_pkg::reg_data_t reg_rdata,
   output logic                  reg_rvalid
);
   import rescale_pkg::*;

   product_t product;
   logic     product_valid;

   scale_cfg_if cfg ();

   scale_regs u_regs (
      .CLK        (CLK),
      .RST        (RST),
      .reg_wr     (reg_wr),
      .reg_rd     (reg_rd),
      .reg_addr   (reg_addr),
      .reg_wdata  (reg_wdata),
      .reg_rdata  (reg_rdata),
      .reg_rvalid (reg_rvalid),
      .cfg        (cfg.regs)
   );

   // One cycle of multiply, then two of rounding, so outputs lag by three.
   gain_multiplier u_mult (
      .CLK           (CLK),
      .RST           (RST),
      .in_sample     (in_sample),
      .in_valid      (in_valid),
      .cfg           (cfg.datapath),
      .product       (product),
      .product_valid (product_valid)
   );

   round_saturate u_round (
      .CLK           (CLK),
      .RST           (RST),
      .product       (product),
      .product_valid (product_valid),
      .out_sample    (out_sample),
      .out_valid     (out_valid),
      .cfg           (cfg.datapath)
   );

endmodule

`default_nettype wire

// ==== hdl/scale_cfg_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface scale_cfg_if;
   import rescale_pkg::*;

   gain_t gain;
   logic  enable;
   logic  clip_inc; // One-cycle pulse per clipped output sample.

   modport regs (
      output gain,
      output enable,
      input  clip_inc
   );

   modport datapath (
      input  gain,
      input  enable,
      output clip_inc
   );

endinterface

`default_nettype wire

// ==== hdl/scale_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module scale_regs (
   input  logic                  CLK,
   input  logic                  RST,
   input  logic                  reg_wr,
   input  logic                  reg_rd,
   input  regmap_pkg::reg_addr_e reg_addr,
   input  regmap_pkg::reg_data_t reg_wdata,
   output regmap_pkg::reg_data_t reg_rdata,
   output logic                  reg_rvalid,
   scale_cfg_if.regs             cfg
);
   import rescale_pkg::*;
   import regmap_pkg::*;

   gain_t                  gain_q;
   logic                   enable_q;
   logic [CLIP_CNT_SZ-1:0] clip_count;
   logic                   clip_clear;

   assign clip_clear = reg_wr && (reg_addr == REG_CLIP_COUNT);

   always_ff @(posedge CLK or posedge RST)
   begin
      if (RST)
      begin
         gain_q   <= gain_t'(GAIN_RESET);
         enable_q <= 1'b0;
      end
      else if (reg_wr)
      begin
         case (reg_addr)
            REG_GAIN: gain_q <= gain_t'(reg_wdata[GAIN_SZ-1:0]);
            REG_CTRL: enable_q <= reg_wdata[0];
            default: ;
         endcase
      end
   end

   // The count sticks at all ones, and a clear on the same edge as an
   // increment wins.
   always_ff @(posedge CLK or posedge RST)
   begin
      if (RST)
      begin
         clip_count <= '0;
      end
      else if (clip_clear)
      begin
         clip_count <= '0;
      end
      else if (cfg.clip_inc && (clip_count != '1))
      begin
         clip_count <= clip_count + 1'b1;
      end
   end

   always_ff @(posedge CLK or posedge RST)
   begin
      if (RST)
      begin
         reg_rdata  <= '0;
         reg_rvalid <= 1'b0;
      end
      else
      begin
         reg_rvalid <= reg_rd; // Data is valid one cycle after the strobe.
         if (reg_rd)
         begin
            case (reg_addr)
               REG_GAIN: reg_rdata <= {{(REG_DATA_SZ-GAIN_SZ){gain_q[GAIN_SZ-1]}}, gain_q};
               REG_CTRL: reg_rdata <= reg_data_t'(enable_q);
               REG_CLIP_COUNT: reg_rdata <= reg_data_t'(clip_count);
               default: reg_rdata <= '0;
            endcase
         end
      end
   end

   assign cfg.gain   = gain_q;
   assign cfg.enable = enable_q;

endmodule

`default_nettype wire

// ==== tb/sample_rescaler_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module sample_rescaler_checker (
   input logic                 CLK,
   input logic                 RST,
   input logic                 in_valid,
   input logic                 out_valid,
   input rescale_pkg::sample_t out_sample,
   input logic                 reg_rd,
   input logic                 reg_rvalid
);
   import rescale_pkg::*;

   int assert_errors = 0; // Read by the testbench for its final verdict.

   // Three pipeline stages sit between an accepted sample and its result.
   assert property (@(posedge CLK) disable iff (RST) out_valid |-> $past(in_valid, 3))
      else
      begin
         $error("out_valid without in_valid three cycles earlier");
         assert_errors++;
      end

   assert property (@(posedge CLK) disable iff (RST) out_valid |-> (out_sample >= -SAT_MAX))
      else
      begin
         $error("out_sample reached the negative full-scale code");
         assert_errors++;
      end

   assert property (@(posedge CLK) disable iff (RST) reg_rvalid == $past(reg_rd))
      else
      begin
         $error("reg_rvalid did not follow reg_rd by one cycle");
         assert_errors++;
      end

endmodule

bind sample_rescaler sample_rescaler_checker u_checker (.*);

`default_nettype wire

// ==== tb/sample_rescaler_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module sample_rescaler_tb;
   import rescale_pkg::*;
   import regmap_pkg::*;

   logic      CLK;
   logic      RST;
   sample_t   in_sample;
   logic      in_valid;
   sample_t   out_sample;
   logic      out_valid;
   logic      reg_wr;
   logic      reg_rd;
   reg_addr_e reg_addr;
   reg_data_t reg_wdata;
   reg_data_t reg_rdata;
   logic      reg_rvalid;

   int      errors = 0;
   int      checks = 0;
   int      cyc = 0;
   integer  seed = 32'h95339dab;
   gain_t   cur_gain = gain_t'(GAIN_RESET); // Gain the model expects in the DUT.
   sample_t exp_q[$];
   int      entry_q[$];

   sample_rescaler dut (.*);

   initial CLK = 1'b0;
   always #5 CLK = ~CLK;

   always @(posedge CLK) cyc <= cyc + 1;

   function automatic sample_t expected_scaled(input sample_t s, input gain_t g);
      longint r;
      r = (longint'(s) * longint'(g) + 16384) >>> FRAC_SZ;
      if (r > SAT_MAX)
         return sample_t'(SAT_MAX);
      if (r < -SAT_MAX)
         return sample_t'(-SAT_MAX);
      return sample_t'(r);
   endfunction

   task automatic check_sample(input string name, input sample_t got, input sample_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      end
   endtask

   task automatic check_reg(input string name, input reg_data_t got, input reg_data_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      end
   endtask

   // Outputs are sampled on the falling edge, half a cycle away from any change.
   always @(negedge CLK)
   begin
      if (!RST && out_valid)
      begin
         if (exp_q.size() == 0)
         begin
            errors++;
            $display("ERROR: out_valid was high with no sample in flight");
         end
         else
         begin
            check_sample("out_sample", out_sample, exp_q.pop_front());
            if (cyc != entry_q.pop_front() + 3)
            begin
               errors++;
               $display("ERROR: a result did not arrive three cycles after its sample");
            end
         end
      end
   end

   // All tasks start and end 1 ns after a rising edge.
   task automatic reg_write(input reg_addr_e addr, input reg_data_t data);
      reg_wr    = 1'b1;
      reg_addr  = addr;
      reg_wdata = data;
      @(posedge CLK);
      #1;
      reg_wr = 1'b0;
   endtask

   task automatic reg_read(input reg_addr_e addr, output reg_data_t data);
      int n;
      reg_rd   = 1'b1;
      reg_addr = addr;
      @(posedge CLK);
      #1;
      reg_rd = 1'b0;
      n = 0;
      while (!reg_rvalid && n < 8)
      begin
         @(posedge CLK);
         #1;
         n++;
      end
      if (!reg_rvalid)
      begin
         errors++;
         $display("ERROR: timed out waiting for read data at %s", addr.name());
      end
      data = reg_rdata;
   endtask

   task automatic send_sample(input sample_t s, input bit expect_out);
      in_valid  = 1'b1;
      in_sample = s;
      if (expect_out)
      begin
         exp_q.push_back(expected_scaled(s, cur_gain));
         entry_q.push_back(cyc);
      end
      @(posedge CLK);
      #1;
      in_valid = 1'b0;
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while (exp_q.size() != 0 && n < 40)
      begin
         @(posedge CLK);
         #1;
         n++;
      end
      if (exp_q.size() != 0)
      begin
         errors++;
         $display("ERROR: %0d samples never came out of the pipeline", exp_q.size());
         exp_q.delete();
         entry_q.delete();
      end
   endtask

   task automatic finish_test(input string name, input int errs_at_start);
      if (errors == errs_at_start)
         $display("%s: ok", name);
      else
         $display("%s: failed with %0d errors", name, errors - errs_at_start);
   endtask

   task automatic reset_defaults();
      int        e0;
      reg_data_t d;
      e0 = errors;
      reg_read(REG_GAIN, d);
      check_reg("gain", d, reg_data_t'(GAIN_RESET));
      reg_read(REG_CTRL, d);
      check_reg("ctrl", d, '0);
      reg_read(REG_CLIP_COUNT, d);
      check_reg("clip_count", d, '0);
      send_sample(16'sd1000, 1'b0); // Dropped while disabled.
      send_sample(-16'sd1000, 1'b0);
      repeat (10) @(posedge CLK);
      #1;
      finish_test("reset_defaults", e0);
   endtask

   task automatic unity_random();
      int e0;
      e0 = errors;
      reg_write(REG_CTRL, 32'd1);
      for (int i = 0; i < 64; i++)
      begin
         send_sample(sample_t'($random(seed)), 1'b1);
      end
      wait_drain();
      finish_test("unity_random", e0);
   endtask

   task automatic rounding_ties();
      int      e0;
      sample_t vals[8] = '{16'sd1, -16'sd1, 16'sd3, -16'sd3, 16'sd2, -16'sd2,
                           16'sd32767, -16'sd32768};
      e0 = errors;
      reg_write(REG_GAIN, 32'd16385);
      cur_gain = gain_t'(16385);
      foreach (vals[i])
         send_sample(vals[i], 1'b1);
      wait_drain();
      finish_test("rounding_ties", e0);
   endtask

   task automatic clip_count();
      int        e0;
      int        nclip;
      reg_data_t d;
      sample_t   vals[7] = '{16'sd20000, -16'sd20000, 16'sd8191, -16'sd8192,
                             16'sd16000, -16'sd9000, 16'sd100};
      e0 = errors;
      nclip = 0;
      reg_write(REG_CLIP_COUNT, '0);
      reg_write(REG_GAIN, 32'd131072);
      cur_gain = gain_t'(131072);
      foreach (vals[i])
      begin
         // A sample clips when its exact scaled value leaves the symmetric range.
         if (longint'(vals[i]) * 4 > SAT_MAX || longint'(vals[i]) * 4 < -SAT_MAX)
            nclip++;
         send_sample(vals[i], 1'b1);
      end
      wait_drain();
      reg_read(REG_CLIP_COUNT, d);
      check_reg("clip_count", d, reg_data_t'(nclip));
      finish_test("clip_count", e0);
   endtask

   task automatic clear_and_gain_change();
      int        e0;
      reg_data_t d;
      e0 = errors;
      reg_write(REG_CLIP_COUNT, '0);
      reg_read(REG_CLIP_COUNT, d);
      check_reg("clip_count", d, '0);
      reg_write(REG_GAIN, reg_data_t'(GAIN_RESET));
      cur_gain = gain_t'(GAIN_RESET);
      send_sample(16'sd1234, 1'b1);
      // A sample on the write edge itself still sees the old gain.
      fork
         send_sample(-16'sd1234, 1'b1);
         reg_write(REG_GAIN, 32'd65536);
      join
      cur_gain = gain_t'(65536);
      send_sample(16'sd1234, 1'b1);
      send_sample(-16'sd1234, 1'b1);
      wait_drain();
      finish_test("clear_and_gain_change", e0);
   endtask

   initial
   begin
      RST       = 1'b1;
      in_sample = '0;
      in_valid  = 1'b0;
      reg_wr    = 1'b0;
      reg_rd    = 1'b0;
      reg_addr  = REG_GAIN;
      reg_wdata = '0;
      repeat (4) @(posedge CLK);
      #1;
      RST = 1'b0;
      reset_defaults();
      unity_random();
      rounding_ties();
      clip_count();
      clear_and_gain_change();
      $display("checks %0d, errors %0d, assertion failures %0d",
               checks, errors, dut.u_checker.assert_errors);
      if (errors == 0 && dut.u_checker.assert_errors == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

   initial
   begin
      #100us;
      $display("ERROR: the run did not finish in time");
      $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

`default_nettype wire
